/* verilog/ctrlsoc_pkg.sv */
// Address map, bus widths, UART timing and shared enums of the control SoC
// Addresses are byte addresses; RAM banks are word addressed internally
// RAM banks sit back to back from address zero, one bank per BANK_BYTES
// CLKS_PER_BIT must match the baud rate of the attached serial device
package ctrlsoc_pkg;

	// Native memory bus
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;

	// On-chip RAM
	localparam int NUM_BANKS = 2;
	localparam int BANK_WORDS = 16384;
	localparam int BANK_AW = $clog2(BANK_WORDS);
	localparam int BANK_BYTES = BANK_WORDS * STRB_W;

	// Register map
	localparam logic [ADDR_W-1:0] LED_ADDR = 32'h0200_0000;
	localparam logic [ADDR_W-1:0] UART_ADDR = 32'h0200_0004;
	localparam int NUM_LEDS = 5;

	// UART, 8N1
	localparam int CLKS_PER_BIT = 104;
	// Holds one and a half bit periods
	localparam int UART_CNT_W = $clog2(3 * CLKS_PER_BIT / 2 + 1);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_DATA,
		RX_STOP
	} uart_rx_state_t;

	typedef enum logic [1:0] {
		REGION_RAM,
		REGION_LED,
		REGION_UART,
		REGION_NONE
	} bus_region_t;

endpackage

/* verilog/ctrlsoc_bus_decode.sv */
// Bus request decoder with the LED register and the sticky bus error
// RAM and LED requests complete one cycle after acceptance
// UART requests are only forwarded; the UART generates its own ready
// An unmapped access is never answered and blocks the bus until reset
`timescale 1ns/1ps

module ctrlsoc_bus_decode
	import ctrlsoc_pkg::*;
(
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 mem_valid,
	input  logic [ADDR_W-1:0]    mem_addr,
	input  logic [DATA_W-1:0]    mem_wdata,
	input  logic [STRB_W-1:0]    mem_wstrb,
	input  logic                 mem_ready,
	output logic [NUM_BANKS-1:0] bank_en,
	output logic                 reg_ready,
	output logic [DATA_W-1:0]    reg_rdata,
	output logic                 uart_wvalid,
	output logic                 uart_rvalid,
	output logic [NUM_LEDS-1:0]  leds,
	output logic                 ledr_n
);
	bus_region_t region;
	logic        accept;
	logic        bus_err;

	always_comb begin
		if (mem_addr < ADDR_W'(NUM_BANKS * BANK_BYTES))
			region = REGION_RAM;
		else if (mem_addr == LED_ADDR)
			region = REGION_LED;
		else if (mem_addr == UART_ADDR)
			region = REGION_UART;
		else
			region = REGION_NONE;
	end

	// No new request while a ready pulse is on the bus
	assign accept = mem_valid && !mem_ready && !bus_err;

	always_comb begin
		for (int i = 0; i < NUM_BANKS; i++)
			bank_en[i] = accept && (region == REGION_RAM) &&
				((mem_addr / ADDR_W'(BANK_BYTES)) == ADDR_W'(i));
	end

	assign uart_wvalid = mem_valid && !bus_err && (region == REGION_UART) && (|mem_wstrb);
	assign uart_rvalid = mem_valid && !bus_err && (region == REGION_UART) && !(|mem_wstrb);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			reg_ready <= 1'b0;
			leds <= '0;
			bus_err <= 1'b0;
		end else begin
			reg_ready <= 1'b0;
			if (accept) begin
				case (region)
					REGION_RAM: reg_ready <= 1'b1;
					REGION_LED: begin
						reg_ready <= 1'b1;
						if (mem_wstrb[0])
							leds <= mem_wdata[NUM_LEDS-1:0];
					end
					REGION_NONE: bus_err <= 1'b1;
					default: ;
				endcase
			end
		end
	end

	// Read data returns the value before a write
	always_ff @(posedge clk) begin
		if (accept && region == REGION_LED)
			reg_rdata <= DATA_W'(leds);
	end

	assign ledr_n = !bus_err;

endmodule

/* verilog/ctrlsoc_ram_bank.sv */
// Single-port synchronous RAM bank with byte-lane writes
// rdata is registered on every enabled cycle, write cycles included,
// and returns the word as it was before that write
`timescale 1ns/1ps

module ctrlsoc_ram_bank
	import ctrlsoc_pkg::*;
(
	input  logic               clk,
	input  logic               en,
	input  logic [BANK_AW-1:0] addr,
	input  logic [STRB_W-1:0]  wstrb,
	input  logic [DATA_W-1:0]  wdata,
	output logic [DATA_W-1:0]  rdata
);
	logic [DATA_W-1:0] mem [BANK_WORDS];

	always_ff @(posedge clk) begin
		if (en) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (wstrb[b])
					mem[addr][8*b +: 8] <= wdata[8*b +: 8];
			end
			rdata <= mem[addr];
		end
	end

endmodule

/* verilog/ctrlsoc_read_return.sv */
// Read data return path for the bus
// Bank data is taken in the cycle after that bank was enabled
// Only one source may signal ready in a given cycle
`timescale 1ns/1ps

module ctrlsoc_read_return
	import ctrlsoc_pkg::*;
(
	input  logic                 clk,
	input  logic                 resetn,
	input  logic [NUM_BANKS-1:0] bank_en,
	input  logic [DATA_W-1:0]    bank_rdata [NUM_BANKS],
	input  logic                 reg_ready,
	input  logic [DATA_W-1:0]    reg_rdata,
	input  logic                 uart_ready,
	input  logic [DATA_W-1:0]    uart_rdata,
	output logic                 mem_ready,
	output logic [DATA_W-1:0]    mem_rdata
);
	logic [NUM_BANKS-1:0] bank_sel;

	always_ff @(posedge clk) begin
		if (!resetn)
			bank_sel <= '0;
		else
			bank_sel <= bank_en;
	end

	assign mem_ready = reg_ready | uart_ready;

	always_comb begin
		mem_rdata = uart_ready ? uart_rdata : reg_rdata;
		for (int i = 0; i < NUM_BANKS; i++) begin
			if (bank_sel[i])
				mem_rdata = bank_rdata[i];
		end
	end

endmodule

/* verilog/ctrlsoc_uart.sv */
// 8N1 UART data register, CLKS_PER_BIT clocks per bit
// Read pops the oldest of up to four received bytes, all ones when empty
// A byte arriving while the buffer is full is lost, and so is a bad stop bit
// Write blocks until the stop bit starts; tx bit timing comes from a
// free-running divider, so the start bit begins up to one bit period late
`timescale 1ns/1ps

module ctrlsoc_uart
	import ctrlsoc_pkg::*;
(
	input  logic              clk,
	input  logic              resetn,
	input  logic              rx,
	input  logic              wvalid,
	input  logic [DATA_W-1:0] wdata,
	input  logic              rvalid,
	input  logic              ready_in,
	output logic              tx,
	output logic [DATA_W-1:0] rdata,
	output logic              ready
);
	logic [UART_CNT_W-1:0] div_cnt;
	logic                  div_pulse;
	logic                  rx_q1;
	logic                  rx_q2;
	logic                  rx_last;
	uart_rx_state_t        rx_state;
	logic [UART_CNT_W-1:0] rx_cnt;
	logic [2:0]            rx_bit;
	logic [7:0]            rx_byte;
	logic                  rx_done;
	logic [31:0]           rbuf;
	logic [3:0]            rbuf_valid;
	logic [8:0]            tx_shift;
	logic [3:0]            tx_cnt;

	assign div_pulse = (div_cnt == UART_CNT_W'(CLKS_PER_BIT - 1));

	always_ff @(posedge clk) begin
		if (!resetn || div_pulse)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	// Receiver
	always_ff @(posedge clk) begin
		if (!resetn) begin
			rx_q1 <= 1'b1;
			rx_q2 <= 1'b1;
			rx_last <= 1'b1;
			rx_state <= RX_IDLE;
			rx_cnt <= '0;
			rx_done <= 1'b0;
		end else begin
			rx_q1 <= rx;
			rx_q2 <= rx_q1;
			rx_last <= rx_q2;
			rx_done <= 1'b0;
			if (rx_cnt != '0)
				rx_cnt <= rx_cnt - 1'b1;
			case (rx_state)
				RX_IDLE: begin
					if (rx_last && !rx_q2) begin
						// Skip start bit, sample mid bit 0
						rx_cnt <= UART_CNT_W'(3 * CLKS_PER_BIT / 2 - 1);
						rx_bit <= '0;
						rx_state <= RX_DATA;
					end
				end
				RX_DATA: begin
					if (rx_cnt == '0) begin
						rx_byte <= {rx_q2, rx_byte[7:1]};
						rx_cnt <= UART_CNT_W'(CLKS_PER_BIT - 1);
						rx_bit <= rx_bit + 1'b1;
						if (rx_bit == 3'd7)
							rx_state <= RX_STOP;
					end
				end
				RX_STOP: begin
					if (rx_cnt == '0) begin
						rx_done <= rx_q2;
						rx_state <= RX_IDLE;
					end
				end
				default: rx_state <= RX_IDLE;
			endcase
		end
	end

	// Receive buffer, transmitter and bus response
	always_ff @(posedge clk) begin
		if (!resetn) begin
			rbuf_valid <= '0;
			tx_shift <= '1;
			tx_cnt <= '0;
			ready <= 1'b0;
		end else begin
			ready <= 1'b0;
			// Storing a byte takes priority, a pending read waits a cycle
			if (rx_done) begin
				case (rbuf_valid)
					4'b0000: rbuf[7:0] <= rx_byte;
					4'b0001: rbuf[15:8] <= rx_byte;
					4'b0011: rbuf[23:16] <= rx_byte;
					4'b0111: rbuf[31:24] <= rx_byte;
					default: ;
				endcase
				rbuf_valid <= {rbuf_valid[2:0], 1'b1};
			end else if (rvalid && !ready_in) begin
				rbuf <= rbuf >> 8;
				rbuf_valid <= rbuf_valid >> 1;
				rdata <= rbuf_valid[0] ? DATA_W'(rbuf[7:0]) : '1;
				ready <= 1'b1;
			end
			if (wvalid && !ready_in && div_pulse) begin
				if (tx_cnt == '0) begin
					tx_shift <= {wdata[7:0], 1'b0};
					tx_cnt <= 4'd9;
				end else begin
					tx_shift <= {1'b1, tx_shift[8:1]};
					tx_cnt <= tx_cnt - 1'b1;
					// Last shift puts the stop bit on the line
					ready <= (tx_cnt == 4'd1);
				end
			end
		end
	end

	assign tx = tx_shift[0];

endmodule

/* verilog/ctrlsoc_top.sv */
// Peripheral side of the control SoC as a native memory bus target
// The master must hold each request until mem_ready and keep only one
// request outstanding; unmapped addresses hang the bus until reset
// ledr_n is active low and shows the sticky bus error
`timescale 1ns/1ps

module ctrlsoc_top
	import ctrlsoc_pkg::*;
(
	input  logic                clk,
	input  logic                resetn,
	input  logic                mem_valid,
	input  logic [ADDR_W-1:0]   mem_addr,
	input  logic [DATA_W-1:0]   mem_wdata,
	input  logic [STRB_W-1:0]   mem_wstrb,
	output logic                mem_ready,
	output logic [DATA_W-1:0]   mem_rdata,
	input  logic                ser_rx,
	output logic                ser_tx,
	output logic [NUM_LEDS-1:0] leds,
	output logic                ledr_n
);
	logic [NUM_BANKS-1:0] bank_en;
	logic [DATA_W-1:0]    bank_rdata [NUM_BANKS];
	logic                 reg_ready;
	logic [DATA_W-1:0]    reg_rdata;
	logic                 uart_wvalid;
	logic                 uart_rvalid;
	logic                 uart_ready;
	logic [DATA_W-1:0]    uart_rdata;

	ctrlsoc_bus_decode decode_i (
		.clk         (clk),
		.resetn      (resetn),
		.mem_valid   (mem_valid),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata),
		.mem_wstrb   (mem_wstrb),
		.mem_ready   (mem_ready),
		.bank_en     (bank_en),
		.reg_ready   (reg_ready),
		.reg_rdata   (reg_rdata),
		.uart_wvalid (uart_wvalid),
		.uart_rvalid (uart_rvalid),
		.leds        (leds),
		.ledr_n      (ledr_n)
	);

	for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
		ctrlsoc_ram_bank ram_bank_i (
			.clk   (clk),
			.en    (bank_en[i]),
			.addr  (mem_addr[BANK_AW+1:2]),
			.wstrb (mem_wstrb),
			.wdata (mem_wdata),
			.rdata (bank_rdata[i])
		);
	end

	ctrlsoc_read_return read_return_i (
		.clk        (clk),
		.resetn     (resetn),
		.bank_en    (bank_en),
		.bank_rdata (bank_rdata),
		.reg_ready  (reg_ready),
		.reg_rdata  (reg_rdata),
		.uart_ready (uart_ready),
		.uart_rdata (uart_rdata),
		.mem_ready  (mem_ready),
		.mem_rdata  (mem_rdata)
	);

	ctrlsoc_uart uart_i (
		.clk      (clk),
		.resetn   (resetn),
		.rx       (ser_rx),
		.wvalid   (uart_wvalid),
		.wdata    (mem_wdata),
		.rvalid   (uart_rvalid),
		.ready_in (mem_ready),
		.tx       (ser_tx),
		.rdata    (uart_rdata),
		.ready    (uart_ready)
	);

endmodule

/* tb/ctrlsoc_props.sv */
// Concurrent checks on the bus handshake, the bus error LED and the UART
// Bound into ctrlsoc_top; decoder region and receiver state are reached
// through the instance names decode_i and uart_i
`timescale 1ns/1ps

module ctrlsoc_props
	import ctrlsoc_pkg::*;
(
	input logic           clk,
	input logic           resetn,
	input logic           mem_valid,
	input logic           mem_ready,
	input logic           ledr_n,
	input logic           ser_tx,
	input bus_region_t    region,
	input uart_rx_state_t rx_state
);
	ready_pulse: assert property (@(posedge clk) disable iff (!resetn)
		mem_ready |=> !mem_ready)
		else $error("mem_ready stayed high for two cycles");

	ready_after_valid: assert property (@(posedge clk) disable iff (!resetn)
		mem_ready |-> $past(mem_valid))
		else $error("mem_ready came without a request in the cycle before");

	// Only a reset clears the error LED
	err_sticky: assert property (@(posedge clk)
		$rose(ledr_n) |-> !$past(resetn))
		else $error("ledr_n went high without a reset");

	err_cause: assert property (@(posedge clk)
		$fell(ledr_n) |-> $past(mem_valid && region == REGION_NONE))
		else $error("ledr_n went low without an unmapped request");

	tx_idle_in_reset: assert property (@(posedge clk)
		!resetn |=> ser_tx)
		else $error("ser_tx was not high during reset");

	// Receiver starts from idle after every reset
	rx_idle_after_reset: assert property (@(posedge clk)
		!resetn |=> rx_state == RX_IDLE)
		else $error("UART receiver was not idle after reset");

endmodule

bind ctrlsoc_top ctrlsoc_props props_i (
	.clk       (clk),
	.resetn    (resetn),
	.mem_valid (mem_valid),
	.mem_ready (mem_ready),
	.ledr_n    (ledr_n),
	.ser_tx    (ser_tx),
	.region    (decode_i.region),
	.rx_state  (uart_i.rx_state)
);

/* tb/ctrlsoc_tb.sv */
// Testbench playing the CPU on the native memory bus of ctrlsoc_top
// Inputs change on the falling edge and outputs are sampled there as well
// RAM is only compared at addresses written since the last reset
`timescale 1ns/1ps

module ctrlsoc_tb
	import ctrlsoc_pkg::*;
();
	localparam int REG_LIMIT = 20;
	localparam int TX_LIMIT = 12 * CLKS_PER_BIT;
	localparam int HANG_LIMIT = 50;
	localparam int MON_IDLE = 50000;
	localparam int NUM_RAND = 8;
	localparam int NUM_TX = 3;

	logic                clk = 1'b0;
	logic                resetn = 1'b0;
	logic                mem_valid = 1'b0;
	logic [ADDR_W-1:0]   mem_addr = '0;
	logic [DATA_W-1:0]   mem_wdata = '0;
	logic [STRB_W-1:0]   mem_wstrb = '0;
	logic                mem_ready;
	logic [DATA_W-1:0]   mem_rdata;
	logic                ser_rx = 1'b1;
	logic                ser_tx;
	logic [NUM_LEDS-1:0] leds;
	logic                ledr_n;

	integer      seed = 32'hd832_3448;
	int          mismatches = 0;
	int          protocol_errs = 0;
	logic [31:0] mirror [logic [31:0]];
	logic [7:0]  rx_model [$];
	logic [7:0]  tx_sent [$];
	logic [7:0]  tx_seen [$];
	string       name_q [$];
	logic [31:0] exp_q [$];
	logic [31:0] act_q [$];

	always #10 clk = ~clk;

	ctrlsoc_top dut_i (.*);

	function automatic void mirror_write(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb);
		logic [31:0] w;
		w = mirror.exists(addr) ? mirror[addr] : 'x;
		for (int b = 0; b < 4; b++) begin
			if (strb[b])
				w[8*b +: 8] = data[8*b +: 8];
		end
		mirror[addr] = w;
	endfunction

	function automatic logic [31:0] ref_ram_read(input logic [31:0] addr);
		return mirror.exists(addr) ? mirror[addr] : 'x;
	endfunction

	// Oldest byte first, all ones once the buffer is drained
	function automatic logic [31:0] ref_uart_read();
		if (rx_model.size() == 0)
			return '1;
		return {24'h0, rx_model.pop_front()};
	endfunction

	task automatic queue_check(input string name, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		name_q.push_back(name);
		exp_q.push_back(exp_v);
		act_q.push_back(act_v);
	endtask

	task automatic bus_cycle(input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] strb, input int limit, output logic [31:0] rdata, output bit got);
		int n;
		n = 0;
		got = 1'b0;
		@(negedge clk);
		mem_valid = 1'b1;
		mem_addr = addr;
		mem_wdata = wdata;
		mem_wstrb = strb;
		while (!got && n < limit) begin
			@(negedge clk);
			got = mem_ready;
			n++;
		end
		rdata = mem_rdata;
		mem_valid = 1'b0;
		mem_wstrb = '0;
	endtask

	task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb, input int limit);
		logic [31:0] unused;
		bit          got;
		bus_cycle(addr, data, strb, limit, unused, got);
		assert (got) else begin
			protocol_errs++;
			$display("Write to %h got no ready within %0d cycles", addr, limit);
		end
		if (got && addr < 32'(NUM_BANKS * BANK_BYTES))
			mirror_write(addr, data, strb);
	endtask

	task automatic bus_read(input logic [31:0] addr, input int limit, output logic [31:0] data);
		bit got;
		bus_cycle(addr, '0, '0, limit, data, got);
		assert (got) else begin
			protocol_errs++;
			$display("Read from %h got no ready within %0d cycles", addr, limit);
		end
	endtask

	task automatic bus_expect_hang(input logic [31:0] addr);
		logic [31:0] unused;
		bit          got;
		bus_cycle(addr, '0, '0, HANG_LIMIT, unused, got);
		assert (!got) else begin
			protocol_errs++;
			$display("Access to %h was answered but should hang", addr);
		end
	endtask

	task automatic uart_send_byte(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		// A fifth byte is dropped by the receiver
		if (rx_model.size() < 4)
			rx_model.push_back(b);
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			ser_rx = frame[i];
			repeat (CLKS_PER_BIT - 1) @(negedge clk);
		end
	endtask

	task automatic apply_reset();
		@(negedge clk);
		resetn = 1'b0;
		repeat (3) @(negedge clk);
		resetn = 1'b1;
	endtask

	// Serial monitor, samples each bit in its middle
	initial begin : tx_monitor
		int         idle;
		logic [7:0] b;
		idle = 0;
		while (idle < MON_IDLE) begin
			@(negedge clk);
			if (resetn && ser_tx === 1'b0) begin
				repeat (CLKS_PER_BIT / 2) @(negedge clk);
				for (int i = 0; i < 8; i++) begin
					repeat (CLKS_PER_BIT) @(negedge clk);
					b[i] = ser_tx;
				end
				repeat (CLKS_PER_BIT) @(negedge clk);
				assert (ser_tx === 1'b1) else begin
					protocol_errs++;
					$display("Missing stop bit on ser_tx");
				end
				tx_seen.push_back(b);
				idle = 0;
			end else begin
				idle++;
			end
		end
	end

	always @(negedge clk) begin : compare
		string       name;
		logic [31:0] exp_v;
		logic [31:0] act_v;
		while (act_q.size() > 0) begin
			name = name_q.pop_front();
			exp_v = exp_q.pop_front();
			act_v = act_q.pop_front();
			assert (act_v === exp_v) else begin
				mismatches++;
				$display("ERROR %s: expected %h, actual %h", name, exp_v, act_v);
			end
		end
	end

	initial begin : stimulus
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] rd;
		logic [3:0]  strb;
		logic [31:0] offs [NUM_RAND];
		time         t0;
		int          n;

		repeat (3) @(negedge clk);
		resetn = 1'b1;

		// Same offset in both banks, then partial writes on top
		for (int i = 0; i < NUM_RAND; i++) begin
			offs[i] = 32'($random(seed)) & 32'(BANK_BYTES - 4);
			for (int k = 0; k < NUM_BANKS; k++)
				bus_write(offs[i] + 32'(k * BANK_BYTES), 32'($random(seed)), 4'hf, REG_LIMIT);
		end
		for (int i = 0; i < NUM_RAND; i++) begin
			strb = 4'($random(seed));
			if (strb == '0)
				strb = 4'b0100;
			addr = offs[i] + ((i % 2) ? 32'(BANK_BYTES) : 32'h0);
			bus_write(addr, 32'($random(seed)), strb, REG_LIMIT);
		end
		for (int i = 0; i < NUM_RAND; i++) begin
			for (int k = 0; k < NUM_BANKS; k++) begin
				addr = offs[i] + 32'(k * BANK_BYTES);
				bus_read(addr, REG_LIMIT, rd);
				queue_check("ram_rw", ref_ram_read(addr), rd);
			end
		end

		data = 32'($random(seed));
		bus_write(LED_ADDR, data, 4'b0001, REG_LIMIT);
		queue_check("led_set", 32'(data[NUM_LEDS-1:0]), 32'(leds));
		bus_write(LED_ADDR, ~data, 4'b1110, REG_LIMIT);
		queue_check("led_keep", 32'(data[NUM_LEDS-1:0]), 32'(leds));
		bus_read(LED_ADDR, REG_LIMIT, rd);
		queue_check("led_read", 32'(data[NUM_LEDS-1:0]), rd);

		uart_send_byte(8'h5a);
		uart_send_byte(8'hc3);
		repeat (3) begin
			data = ref_uart_read();
			bus_read(UART_ADDR, REG_LIMIT, rd);
			queue_check("uart_rx", data, rd);
		end
		for (int i = 0; i < 5; i++)
			uart_send_byte(8'($random(seed)));
		repeat (5) begin
			data = ref_uart_read();
			bus_read(UART_ADDR, REG_LIMIT, rd);
			queue_check("uart_rx_full", data, rd);
		end

		for (int i = 0; i < NUM_TX; i++) begin
			data = 32'($random(seed));
			tx_sent.push_back(data[7:0]);
			t0 = $time;
			bus_write(UART_ADDR, data, 4'b0001, TX_LIMIT);
			assert ($time - t0 >= 9 * CLKS_PER_BIT * 20) else begin
				protocol_errs++;
				$display("UART write returned before the frame was sent");
			end
		end
		n = 0;
		while (tx_seen.size() < NUM_TX && n < 2 * CLKS_PER_BIT) begin
			@(negedge clk);
			n++;
		end
		assert (tx_seen.size() == NUM_TX) else begin
			protocol_errs++;
			$display("Serial monitor saw %0d bytes instead of %0d", tx_seen.size(), NUM_TX);
		end
		while (tx_seen.size() > 0 && tx_sent.size() > 0)
			queue_check("uart_tx", 32'(tx_sent.pop_front()), 32'(tx_seen.pop_front()));

		// Dropped flash region, then a blocked RAM read
		bus_expect_hang(32'h0002_0000);
		queue_check("bus_err_set", 32'd0, 32'(ledr_n));
		bus_expect_hang(32'h0000_0010);
		apply_reset();
		mirror.delete();
		rx_model.delete();
		queue_check("bus_err_clear", 32'd1, 32'(ledr_n));
		data = 32'($random(seed));
		bus_write(32'h0000_0010, data, 4'hf, REG_LIMIT);
		bus_read(32'h0000_0010, REG_LIMIT, rd);
		queue_check("ram_after_reset", ref_ram_read(32'h0000_0010), rd);
		bus_expect_hang(LED_ADDR + 32'h8);
		queue_check("bus_err_again", 32'd0, 32'(ledr_n));

		repeat (2) @(negedge clk);
		$display("Checks done: %0d value errors, %0d protocol errors",
			mismatches, protocol_errs);
		if (mismatches == 0 && protocol_errs == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* list.f */
verilog/ctrlsoc_pkg.sv
verilog/ctrlsoc_bus_decode.sv
verilog/ctrlsoc_ram_bank.sv
verilog/ctrlsoc_read_return.sv
verilog/ctrlsoc_uart.sv
verilog/ctrlsoc_top.sv
tb/ctrlsoc_props.sv
tb/ctrlsoc_tb.sv

/* Bender.yml */
package:
  name: ctrlsoc

sources:
  - files:
      - verilog/ctrlsoc_pkg.sv
      - verilog/ctrlsoc_bus_decode.sv
      - verilog/ctrlsoc_ram_bank.sv
      - verilog/ctrlsoc_read_return.sv
      - verilog/ctrlsoc_uart.sv
      - verilog/ctrlsoc_top.sv
  - target: test
    files:
      - tb/ctrlsoc_props.sv
      - tb/ctrlsoc_tb.sv
